//--- logic/rs_cfg_pkg.sv
// Reservation station geometry
// Default entry count, port widths and physical tag width
package rs_cfg_pkg;

    // Station size and port counts, used as top-level defaults
    localparam int RS_ENTRY_NUM_DEF = 8;
    localparam int RS_DP_NUM_DEF    = 2;
    localparam int RS_IS_NUM_DEF    = 2;
    localparam int RS_CDB_NUM_DEF   = 2;

    // Physical register tag width
    localparam int TAG_W = 6;

endpackage

//--- logic/rs_fu_pkg.sv
// Functional-unit classes
// Class codes and the opaque operation payload carried to the units
package rs_fu_pkg;

    // Class codes
    localparam int FU_ALU  = 0;
    localparam int FU_MULT = 1;
    localparam int FU_MEM  = 2;
    localparam int FU_BR   = 3;

    // Number of classes and code width
    localparam int FU_NUM = 4;
    localparam int FU_W   = 2;

    // Operation payload, not decoded inside the station
    localparam int OP_W = 16;

endpackage

//--- logic/rs_multi_pick.sv
// Multi-output priority picker
// Finds the PICK_NUM lowest set bits of a request vector
module rs_multi_pick #(
    parameter int  WIDTH    = 8,
    parameter int  PICK_NUM = 2,
    localparam int IDX_W    = $clog2(WIDTH)
) (
    input  logic [WIDTH-1:0]                req_i,
    output logic [PICK_NUM-1:0][IDX_W-1:0]  idx_o,
    output logic [PICK_NUM-1:0]             vld_o
);

    // ------------------------------------------------------------------------
    // Encoder cascade
    // ------------------------------------------------------------------------
    // Stage k sees the requests left after stages 0..k-1 took their bit
    always_comb begin
        logic [WIDTH-1:0] remain;
        remain = req_i;
        idx_o  = '0;
        vld_o  = '0;
        for (int k = 0; k < PICK_NUM; k++) begin
            // Scan downwards so the lowest set bit wins
            for (int b = WIDTH - 1; b >= 0; b--) begin
                if (remain[b]) begin
                    idx_o[k] = IDX_W'(b);
                end
            end
            vld_o[k] = |remain;
            // Mask the bit this stage found
            if (vld_o[k]) begin
                remain[idx_o[k]] = 1'b0;
            end
        end
    end

endmodule

//--- logic/rs_alloc.sv
// Dispatch allocation for the reservation station
// Picks free entries, routes dispatch channels to them, counts availability
module rs_alloc #(
    parameter int  ENTRY_NUM = 8,
    parameter int  DP_NUM    = 2,
    localparam int CNT_W     = $clog2(DP_NUM + 1)
) (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    // Entry state from the array and the issue picker
    input  logic [ENTRY_NUM-1:0]                         entry_valid_i,
    input  logic [ENTRY_NUM-1:0]                         issue_sel_i,
    // Dispatch channels
    input  logic [CNT_W-1:0]                             dp_num_i,
    input  logic [DP_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]     dp_dst_tag_i,
    input  logic [DP_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]     dp_src1_tag_i,
    input  logic [DP_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]     dp_src2_tag_i,
    input  logic [DP_NUM-1:0]                            dp_src1_rdy_i,
    input  logic [DP_NUM-1:0]                            dp_src2_rdy_i,
    input  logic [DP_NUM-1:0][rs_fu_pkg::FU_W-1:0]       dp_fu_i,
    input  logic [DP_NUM-1:0][rs_fu_pkg::OP_W-1:0]       dp_op_i,
    // Per-entry write strobes and routed contents
    output logic [ENTRY_NUM-1:0]                         dp_sel_o,
    output logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  ent_dst_tag_o,
    output logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  ent_src1_tag_o,
    output logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  ent_src2_tag_o,
    output logic [ENTRY_NUM-1:0]                         ent_src1_rdy_o,
    output logic [ENTRY_NUM-1:0]                         ent_src2_rdy_o,
    output logic [ENTRY_NUM-1:0][rs_fu_pkg::FU_W-1:0]    ent_fu_o,
    output logic [ENTRY_NUM-1:0][rs_fu_pkg::OP_W-1:0]    ent_op_o,
    // Entries the dispatcher may fill this cycle
    output logic [CNT_W-1:0]                             avail_num_o
);

    localparam int IDX_W  = $clog2(ENTRY_NUM);
    localparam int FREE_W = $clog2(ENTRY_NUM + 1);

    logic [ENTRY_NUM-1:0]             free;
    logic [DP_NUM-1:0][IDX_W-1:0]     pick_idx;
    logic [DP_NUM-1:0]                pick_vld;
    logic [FREE_W-1:0]                free_cnt;

    // An entry leaving by issue this cycle can be refilled at the same edge
    assign free = ~entry_valid_i | issue_sel_i;

    rs_multi_pick #(
        .WIDTH    (ENTRY_NUM),
        .PICK_NUM (DP_NUM)
    ) i_pick (
        .req_i (free),
        .idx_o (pick_idx),
        .vld_o (pick_vld)
    );

    // ------------------------------------------------------------------------
    // Dispatch routing
    // ------------------------------------------------------------------------
    // Channel k goes to the k-th lowest free entry
    always_comb begin
        dp_sel_o       = '0;
        ent_dst_tag_o  = '0;
        ent_src1_tag_o = '0;
        ent_src2_tag_o = '0;
        ent_src1_rdy_o = '0;
        ent_src2_rdy_o = '0;
        ent_fu_o       = '0;
        ent_op_o       = '0;
        for (int k = 0; k < DP_NUM; k++) begin
            // Only the low dp_num_i channels carry an instruction
            if (pick_vld[k] && (CNT_W'(k) < dp_num_i)) begin
                dp_sel_o[pick_idx[k]]       = 1'b1;
                ent_dst_tag_o[pick_idx[k]]  = dp_dst_tag_i[k];
                ent_src1_tag_o[pick_idx[k]] = dp_src1_tag_i[k];
                ent_src2_tag_o[pick_idx[k]] = dp_src2_tag_i[k];
                ent_src1_rdy_o[pick_idx[k]] = dp_src1_rdy_i[k];
                ent_src2_rdy_o[pick_idx[k]] = dp_src2_rdy_i[k];
                ent_fu_o[pick_idx[k]]       = dp_fu_i[k];
                ent_op_o[pick_idx[k]]       = dp_op_i[k];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Availability count
    // ------------------------------------------------------------------------
    always_comb begin
        free_cnt = '0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            free_cnt = free_cnt + FREE_W'(free[e]);
        end
        // Saturate at the dispatch width
        if (free_cnt >= FREE_W'(DP_NUM)) begin
            avail_num_o = CNT_W'(DP_NUM);
        end else begin
            avail_num_o = CNT_W'(free_cnt);
        end
    end

    // Dispatcher must respect the count it was given
    a_dp_within_avail : assert property (
        @(posedge clk_i) disable iff (rst_i) dp_num_i <= avail_num_o
    ) else $error("dispatch count exceeds available entries");

endmodule

//--- logic/rs_entry_array.sv
// Reservation station entry storage
// Holds entries, applies CDB wakeup and computes the per-entry ready level
module rs_entry_array #(
    parameter int ENTRY_NUM = 8,
    parameter int CDB_NUM   = 2
) (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic                                         squash_i,
    // Routed dispatch contents
    input  logic [ENTRY_NUM-1:0]                         dp_sel_i,
    input  logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  ent_dst_tag_i,
    input  logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  ent_src1_tag_i,
    input  logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  ent_src2_tag_i,
    input  logic [ENTRY_NUM-1:0]                         ent_src1_rdy_i,
    input  logic [ENTRY_NUM-1:0]                         ent_src2_rdy_i,
    input  logic [ENTRY_NUM-1:0][rs_fu_pkg::FU_W-1:0]    ent_fu_i,
    input  logic [ENTRY_NUM-1:0][rs_fu_pkg::OP_W-1:0]    ent_op_i,
    // Result buses
    input  logic [CDB_NUM-1:0]                           cdb_valid_i,
    input  logic [CDB_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]    cdb_tag_i,
    // Unit class ready levels
    input  logic [rs_fu_pkg::FU_NUM-1:0]                 fu_ready_i,
    // Entries leaving this cycle
    input  logic [ENTRY_NUM-1:0]                         issue_sel_i,
    output logic [ENTRY_NUM-1:0]                         entry_valid_o,
    output logic [ENTRY_NUM-1:0]                         ready_o,
    // Stored contents
    output logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  st_dst_tag_o,
    output logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  st_src1_tag_o,
    output logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  st_src2_tag_o,
    output logic [ENTRY_NUM-1:0][rs_fu_pkg::FU_W-1:0]    st_fu_o,
    output logic [ENTRY_NUM-1:0][rs_fu_pkg::OP_W-1:0]    st_op_o
);

    logic [ENTRY_NUM-1:0] src1_rdy;
    logic [ENTRY_NUM-1:0] src2_rdy;
    logic [ENTRY_NUM-1:0] wake1;
    logic [ENTRY_NUM-1:0] wake2;

    // ------------------------------------------------------------------------
    // CDB comparator network
    // ------------------------------------------------------------------------
    // Every valid entry against every valid bus
    always_comb begin
        wake1 = '0;
        wake2 = '0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            for (int c = 0; c < CDB_NUM; c++) begin
                if (entry_valid_o[e] && cdb_valid_i[c]) begin
                    if (cdb_tag_i[c] == st_src1_tag_o[e]) begin
                        wake1[e] = 1'b1;
                    end
                    if (cdb_tag_i[c] == st_src2_tag_o[e]) begin
                        wake2[e] = 1'b1;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Ready check
    // ------------------------------------------------------------------------
    // Both sources present and the entry's unit class accepting
    always_comb begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            ready_o[e] = entry_valid_o[e] && src1_rdy[e] && src2_rdy[e]
                      && fu_ready_i[st_fu_o[e]] && !squash_i;
        end
    end

    // ------------------------------------------------------------------------
    // Entry update
    // ------------------------------------------------------------------------
    // Squash, then dispatch, then issue clear, then wakeup
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            if (rst_i || squash_i) begin
                entry_valid_o[e] <= 1'b0;
                src1_rdy[e]      <= 1'b0;
                src2_rdy[e]      <= 1'b0;
            end else if (dp_sel_i[e]) begin
                // A strobe in the dispatch cycle is lost for this entry
                entry_valid_o[e] <= 1'b1;
                src1_rdy[e]      <= ent_src1_rdy_i[e];
                src2_rdy[e]      <= ent_src2_rdy_i[e];
            end else if (issue_sel_i[e]) begin
                entry_valid_o[e] <= 1'b0;
            end else begin
                // Sources wake independently
                if (wake1[e]) begin
                    src1_rdy[e] <= 1'b1;
                end
                if (wake2[e]) begin
                    src2_rdy[e] <= 1'b1;
                end
            end
        end
    end

    // Payload only changes on a dispatch write
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            if (dp_sel_i[e]) begin
                st_dst_tag_o[e]  <= ent_dst_tag_i[e];
                st_src1_tag_o[e] <= ent_src1_tag_i[e];
                st_src2_tag_o[e] <= ent_src2_tag_i[e];
                st_fu_o[e]       <= ent_fu_i[e];
                st_op_o[e]       <= ent_op_i[e];
            end
        end
    end

    // Allocation only ever overwrites entries that are free or leaving
    a_dp_on_free : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (dp_sel_i & entry_valid_o & ~issue_sel_i) == '0
    ) else $error("dispatch targets an occupied entry");

endmodule

//--- logic/rs_issue_select.sv
// Issue selection for the reservation station
// Takes the lowest-index ready entries and drives them onto issue channels
module rs_issue_select #(
    parameter int ENTRY_NUM = 8,
    parameter int IS_NUM    = 2
) (
    input  logic [ENTRY_NUM-1:0]                         ready_i,
    input  logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  st_dst_tag_i,
    input  logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  st_src1_tag_i,
    input  logic [ENTRY_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  st_src2_tag_i,
    input  logic [ENTRY_NUM-1:0][rs_fu_pkg::FU_W-1:0]    st_fu_i,
    input  logic [ENTRY_NUM-1:0][rs_fu_pkg::OP_W-1:0]    st_op_i,
    output logic [ENTRY_NUM-1:0]                         issue_sel_o,
    // Issue channels
    output logic [IS_NUM-1:0]                            is_valid_o,
    output logic [IS_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]     is_dst_tag_o,
    output logic [IS_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]     is_src1_tag_o,
    output logic [IS_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]     is_src2_tag_o,
    output logic [IS_NUM-1:0][rs_fu_pkg::FU_W-1:0]       is_fu_o,
    output logic [IS_NUM-1:0][rs_fu_pkg::OP_W-1:0]       is_op_o
);

    localparam int IDX_W = $clog2(ENTRY_NUM);

    logic [IS_NUM-1:0][IDX_W-1:0] pick_idx;
    logic [IS_NUM-1:0]            pick_vld;

    rs_multi_pick #(
        .WIDTH    (ENTRY_NUM),
        .PICK_NUM (IS_NUM)
    ) i_pick (
        .req_i (ready_i),
        .idx_o (pick_idx),
        .vld_o (pick_vld)
    );

    // ------------------------------------------------------------------------
    // Issue switch
    // ------------------------------------------------------------------------
    // Idle channels carry zeros
    always_comb begin
        issue_sel_o   = '0;
        is_valid_o    = pick_vld;
        is_dst_tag_o  = '0;
        is_src1_tag_o = '0;
        is_src2_tag_o = '0;
        is_fu_o       = '0;
        is_op_o       = '0;
        for (int j = 0; j < IS_NUM; j++) begin
            if (pick_vld[j]) begin
                issue_sel_o[pick_idx[j]] = 1'b1;
                is_dst_tag_o[j]          = st_dst_tag_i[pick_idx[j]];
                is_src1_tag_o[j]         = st_src1_tag_i[pick_idx[j]];
                is_src2_tag_o[j]         = st_src2_tag_i[pick_idx[j]];
                is_fu_o[j]               = st_fu_i[pick_idx[j]];
                is_op_o[j]               = st_op_i[pick_idx[j]];
            end
        end
    end

    // One entry per live channel, so the picker never repeats an index
    always_comb begin
        a_is_distinct : assert final ($countones(issue_sel_o) == $countones(is_valid_o))
            else $error("two issue channels share one entry");
    end

endmodule

//--- logic/rs_top.sv
// Reservation station top level
// Connects dispatch allocation, entry storage and issue selection
module rs_top #(
    parameter int  ENTRY_NUM = rs_cfg_pkg::RS_ENTRY_NUM_DEF,
    parameter int  DP_NUM    = rs_cfg_pkg::RS_DP_NUM_DEF,
    parameter int  IS_NUM    = rs_cfg_pkg::RS_IS_NUM_DEF,
    parameter int  CDB_NUM   = rs_cfg_pkg::RS_CDB_NUM_DEF,
    localparam int CNT_W     = $clog2(DP_NUM + 1)
) (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic                                      squash_i,
    // Dispatch
    input  logic [CNT_W-1:0]                          dp_num_i,
    input  logic [DP_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  dp_dst_tag_i,
    input  logic [DP_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  dp_src1_tag_i,
    input  logic [DP_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  dp_src2_tag_i,
    input  logic [DP_NUM-1:0]                         dp_src1_rdy_i,
    input  logic [DP_NUM-1:0]                         dp_src2_rdy_i,
    input  logic [DP_NUM-1:0][rs_fu_pkg::FU_W-1:0]    dp_fu_i,
    input  logic [DP_NUM-1:0][rs_fu_pkg::OP_W-1:0]    dp_op_i,
    output logic [CNT_W-1:0]                          avail_num_o,
    // Result buses and unit ready levels
    input  logic [CDB_NUM-1:0]                        cdb_valid_i,
    input  logic [CDB_NUM-1:0][rs_cfg_pkg::TAG_W-1:0] cdb_tag_i,
    input  logic [rs_fu_pkg::FU_NUM-1:0]              fu_ready_i,
    // Issue
    output logic [IS_NUM-1:0]                         is_valid_o,
    output logic [IS_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  is_dst_tag_o,
    output logic [IS_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  is_src1_tag_o,
    output logic [IS_NUM-1:0][rs_cfg_pkg::TAG_W-1:0]  is_src2_tag_o,
    output logic [IS_NUM-1:0][rs_fu_pkg::FU_W-1:0]    is_fu_o,
    output logic [IS_NUM-1:0][rs_fu_pkg::OP_W-1:0]    is_op_o
);

    import rs_cfg_pkg::*;
    import rs_fu_pkg::*;

    // Entry state and selection vectors
    logic [ENTRY_NUM-1:0]             entry_valid;
    logic [ENTRY_NUM-1:0]             ready;
    logic [ENTRY_NUM-1:0]             issue_sel;
    logic [ENTRY_NUM-1:0]             dp_sel;

    // Routed dispatch contents
    logic [ENTRY_NUM-1:0][TAG_W-1:0]  ent_dst_tag;
    logic [ENTRY_NUM-1:0][TAG_W-1:0]  ent_src1_tag;
    logic [ENTRY_NUM-1:0][TAG_W-1:0]  ent_src2_tag;
    logic [ENTRY_NUM-1:0]             ent_src1_rdy;
    logic [ENTRY_NUM-1:0]             ent_src2_rdy;
    logic [ENTRY_NUM-1:0][FU_W-1:0]   ent_fu;
    logic [ENTRY_NUM-1:0][OP_W-1:0]   ent_op;

    // Stored contents
    logic [ENTRY_NUM-1:0][TAG_W-1:0]  st_dst_tag;
    logic [ENTRY_NUM-1:0][TAG_W-1:0]  st_src1_tag;
    logic [ENTRY_NUM-1:0][TAG_W-1:0]  st_src2_tag;
    logic [ENTRY_NUM-1:0][FU_W-1:0]   st_fu;
    logic [ENTRY_NUM-1:0][OP_W-1:0]   st_op;

    rs_alloc #(
        .ENTRY_NUM (ENTRY_NUM),
        .DP_NUM    (DP_NUM)
    ) i_alloc (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .entry_valid_i  (entry_valid),
        .issue_sel_i    (issue_sel),
        .dp_num_i       (dp_num_i),
        .dp_dst_tag_i   (dp_dst_tag_i),
        .dp_src1_tag_i  (dp_src1_tag_i),
        .dp_src2_tag_i  (dp_src2_tag_i),
        .dp_src1_rdy_i  (dp_src1_rdy_i),
        .dp_src2_rdy_i  (dp_src2_rdy_i),
        .dp_fu_i        (dp_fu_i),
        .dp_op_i        (dp_op_i),
        .dp_sel_o       (dp_sel),
        .ent_dst_tag_o  (ent_dst_tag),
        .ent_src1_tag_o (ent_src1_tag),
        .ent_src2_tag_o (ent_src2_tag),
        .ent_src1_rdy_o (ent_src1_rdy),
        .ent_src2_rdy_o (ent_src2_rdy),
        .ent_fu_o       (ent_fu),
        .ent_op_o       (ent_op),
        .avail_num_o    (avail_num_o)
    );

    rs_entry_array #(
        .ENTRY_NUM (ENTRY_NUM),
        .CDB_NUM   (CDB_NUM)
    ) i_array (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .squash_i       (squash_i),
        .dp_sel_i       (dp_sel),
        .ent_dst_tag_i  (ent_dst_tag),
        .ent_src1_tag_i (ent_src1_tag),
        .ent_src2_tag_i (ent_src2_tag),
        .ent_src1_rdy_i (ent_src1_rdy),
        .ent_src2_rdy_i (ent_src2_rdy),
        .ent_fu_i       (ent_fu),
        .ent_op_i       (ent_op),
        .cdb_valid_i    (cdb_valid_i),
        .cdb_tag_i      (cdb_tag_i),
        .fu_ready_i     (fu_ready_i),
        .issue_sel_i    (issue_sel),
        .entry_valid_o  (entry_valid),
        .ready_o        (ready),
        .st_dst_tag_o   (st_dst_tag),
        .st_src1_tag_o  (st_src1_tag),
        .st_src2_tag_o  (st_src2_tag),
        .st_fu_o        (st_fu),
        .st_op_o        (st_op)
    );

    rs_issue_select #(
        .ENTRY_NUM (ENTRY_NUM),
        .IS_NUM    (IS_NUM)
    ) i_issue (
        .ready_i       (ready),
        .st_dst_tag_i  (st_dst_tag),
        .st_src1_tag_i (st_src1_tag),
        .st_src2_tag_i (st_src2_tag),
        .st_fu_i       (st_fu),
        .st_op_i       (st_op),
        .issue_sel_o   (issue_sel),
        .is_valid_o    (is_valid_o),
        .is_dst_tag_o  (is_dst_tag_o),
        .is_src1_tag_o (is_src1_tag_o),
        .is_src2_tag_o (is_src2_tag_o),
        .is_fu_o       (is_fu_o),
        .is_op_o       (is_op_o)
    );

endmodule

//--- sim/rs_model.svh
// Reservation station reference model
// Entry state, per-cycle issue prediction, edge update and stimulus LFSR
`ifndef RS_MODEL_SVH
`define RS_MODEL_SVH

// Model entry array
logic             m_valid [ENTRY_NUM];
logic [TAG_W-1:0] m_dst   [ENTRY_NUM];
logic [TAG_W-1:0] m_src1  [ENTRY_NUM];
logic [TAG_W-1:0] m_src2  [ENTRY_NUM];
logic             m_rdy1  [ENTRY_NUM];
logic             m_rdy2  [ENTRY_NUM];
logic [FU_W-1:0]  m_fu    [ENTRY_NUM];
logic [OP_W-1:0]  m_op    [ENTRY_NUM];

// Prediction for the current cycle
int               pick_idx [IS_NUM];
logic             pick_vld [IS_NUM];
logic             leaving  [ENTRY_NUM];

// Bookkeeping for the final tag balance
int               dispatched_cnt;
int               squashed_cnt;
int               issued_cnt;

logic [31:0]      lfsr_q;

// ------------------------------------------------------------------------
// Stimulus LFSR
// ------------------------------------------------------------------------
// Fibonacci form, taps 32 22 2 1
function automatic logic next_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
endfunction

// One LFSR step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], next_bit()};
    end
    return v;
endfunction

// ------------------------------------------------------------------------
// Prediction
// ------------------------------------------------------------------------
// Lowest-index ready entries leave, at most IS_NUM of them
function automatic void predict_issue();
    int j;
    j = 0;
    for (int k = 0; k < IS_NUM; k++) begin
        pick_vld[k] = 1'b0;
        pick_idx[k] = 0;
    end
    for (int e = 0; e < ENTRY_NUM; e++) begin
        leaving[e] = 1'b0;
        if (m_valid[e] && m_rdy1[e] && m_rdy2[e] && fu_ready_i[m_fu[e]]
                && !squash_i && j < IS_NUM) begin
            pick_vld[j] = 1'b1;
            pick_idx[j] = e;
            leaving[e]  = 1'b1;
            j++;
        end
    end
endfunction

// Free or leaving entries, capped at the dispatch width
function automatic int predict_avail();
    int n = 0;
    for (int e = 0; e < ENTRY_NUM; e++) begin
        if (!m_valid[e] || leaving[e]) begin
            n++;
        end
    end
    return (n > DP_NUM) ? DP_NUM : n;
endfunction

function automatic logic model_empty();
    for (int e = 0; e < ENTRY_NUM; e++) begin
        if (m_valid[e]) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

// ------------------------------------------------------------------------
// Clock edge
// ------------------------------------------------------------------------
// Squash, then dispatch, then issue clear, then wakeup
function automatic void apply_edge();
    int   k;
    logic free;
    logic wake1;
    logic wake2;
    k = 0;
    dispatched_cnt += int'(dp_num_i);
    if (squash_i) begin
        squashed_cnt += int'(dp_num_i);
    end
    for (int e = 0; e < ENTRY_NUM; e++) begin
        free  = !m_valid[e] || leaving[e];
        wake1 = 1'b0;
        wake2 = 1'b0;
        for (int c = 0; c < CDB_NUM; c++) begin
            if (m_valid[e] && cdb_valid_i[c]) begin
                wake1 = wake1 | (cdb_tag_i[c] == m_src1[e]);
                wake2 = wake2 | (cdb_tag_i[c] == m_src2[e]);
            end
        end
        if (squash_i) begin
            if (m_valid[e]) begin
                squashed_cnt++;
            end
            m_valid[e] = 1'b0;
        end else if (free && k < int'(dp_num_i)) begin
            // k-th free entry takes channel k
            m_valid[e] = 1'b1;
            m_dst[e]   = dp_dst_tag_i[k];
            m_src1[e]  = dp_src1_tag_i[k];
            m_src2[e]  = dp_src2_tag_i[k];
            m_rdy1[e]  = dp_src1_rdy_i[k];
            m_rdy2[e]  = dp_src2_rdy_i[k];
            m_fu[e]    = dp_fu_i[k];
            m_op[e]    = dp_op_i[k];
        end else if (leaving[e]) begin
            m_valid[e] = 1'b0;
        end else begin
            m_rdy1[e] = m_rdy1[e] | wake1;
            m_rdy2[e] = m_rdy2[e] | wake2;
        end
        if (free) begin
            k++;
        end
    end
endfunction

`endif

//--- sim/tb_rs_top.sv
// Reservation station testbench
// Random dispatch, wakeup, unit-ready and squash traffic checked against a model
module tb_rs_top;

    timeunit 1ns;
    timeprecision 100ps;

    import rs_cfg_pkg::*;
    import rs_fu_pkg::*;

    localparam int ENTRY_NUM     = RS_ENTRY_NUM_DEF;
    localparam int DP_NUM        = RS_DP_NUM_DEF;
    localparam int IS_NUM        = RS_IS_NUM_DEF;
    localparam int CDB_NUM       = RS_CDB_NUM_DEF;
    localparam int CNT_W         = $clog2(DP_NUM + 1);
    localparam int RST_CYCLES    = 16;
    localparam int RUN_CYCLES    = 3000;
    // Enough cycles to put every tag on a bus once
    localparam int BCAST_CYCLES  = (1 << TAG_W) / CDB_NUM;
    localparam int DRAIN_TIMEOUT = 200;

    logic                             clk_i;
    logic                             rst_i;
    logic                             squash_i;
    logic [CNT_W-1:0]                 dp_num_i;
    logic [DP_NUM-1:0][TAG_W-1:0]     dp_dst_tag_i;
    logic [DP_NUM-1:0][TAG_W-1:0]     dp_src1_tag_i;
    logic [DP_NUM-1:0][TAG_W-1:0]     dp_src2_tag_i;
    logic [DP_NUM-1:0]                dp_src1_rdy_i;
    logic [DP_NUM-1:0]                dp_src2_rdy_i;
    logic [DP_NUM-1:0][FU_W-1:0]      dp_fu_i;
    logic [DP_NUM-1:0][OP_W-1:0]      dp_op_i;
    logic [CNT_W-1:0]                 avail_num_o;
    logic [CDB_NUM-1:0]               cdb_valid_i;
    logic [CDB_NUM-1:0][TAG_W-1:0]    cdb_tag_i;
    logic [FU_NUM-1:0]                fu_ready_i;
    logic [IS_NUM-1:0]                is_valid_o;
    logic [IS_NUM-1:0][TAG_W-1:0]     is_dst_tag_o;
    logic [IS_NUM-1:0][TAG_W-1:0]     is_src1_tag_o;
    logic [IS_NUM-1:0][TAG_W-1:0]     is_src2_tag_o;
    logic [IS_NUM-1:0][FU_W-1:0]      is_fu_o;
    logic [IS_NUM-1:0][OP_W-1:0]      is_op_o;

    // Next destination tag handed out, increasing
    logic [TAG_W-1:0]                 next_tag;

    `include "rs_model.svh"

    rs_top #(
        .ENTRY_NUM (ENTRY_NUM),
        .DP_NUM    (DP_NUM),
        .IS_NUM    (IS_NUM),
        .CDB_NUM   (CDB_NUM)
    ) i_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .squash_i      (squash_i),
        .dp_num_i      (dp_num_i),
        .dp_dst_tag_i  (dp_dst_tag_i),
        .dp_src1_tag_i (dp_src1_tag_i),
        .dp_src2_tag_i (dp_src2_tag_i),
        .dp_src1_rdy_i (dp_src1_rdy_i),
        .dp_src2_rdy_i (dp_src2_rdy_i),
        .dp_fu_i       (dp_fu_i),
        .dp_op_i       (dp_op_i),
        .avail_num_o   (avail_num_o),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_tag_i     (cdb_tag_i),
        .fu_ready_i    (fu_ready_i),
        .is_valid_o    (is_valid_o),
        .is_dst_tag_o  (is_dst_tag_o),
        .is_src1_tag_o (is_src1_tag_o),
        .is_src2_tag_o (is_src2_tag_o),
        .is_fu_o       (is_fu_o),
        .is_op_o       (is_op_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic stop_on_failure(input string reason);
        $display("Simulation FAILED");
        $display("%s", reason);
        $fatal(1, "stopped at first failure");
    endtask

    // ------------------------------------------------------------------------
    // Stimulus, all driven on the falling edge
    // ------------------------------------------------------------------------
    task automatic drive_random();
        int avail;
        // Rare squash, units mostly ready
        squash_i = (rand_bits(6) == 32'd0);
        for (int f = 0; f < FU_NUM; f++) begin
            fu_ready_i[f] = (rand_bits(2) != 32'd0);
        end
        // Bus tags drawn from recent producers so wakeups actually hit
        for (int c = 0; c < CDB_NUM; c++) begin
            cdb_valid_i[c] = next_bit();
            cdb_tag_i[c]   = next_tag - TAG_W'(1) - TAG_W'(rand_bits(3));
        end
        predict_issue();
        avail    = predict_avail();
        dp_num_i = CNT_W'(rand_bits(CNT_W) % (avail + 1));
        for (int k = 0; k < DP_NUM; k++) begin
            dp_dst_tag_i[k]  = next_tag + TAG_W'(k);
            dp_src1_tag_i[k] = next_tag - TAG_W'(1) - TAG_W'(rand_bits(3));
            dp_src2_tag_i[k] = next_tag - TAG_W'(1) - TAG_W'(rand_bits(3));
            dp_src1_rdy_i[k] = (rand_bits(2) != 32'd0);
            dp_src2_rdy_i[k] = (rand_bits(2) != 32'd0);
            dp_fu_i[k]       = FU_W'(rand_bits(FU_W));
            dp_op_i[k]       = OP_W'(rand_bits(OP_W));
        end
        next_tag = next_tag + TAG_W'(dp_num_i);
    endtask

    // No dispatch, all units ready, buses sweep the whole tag space
    task automatic drive_drain(input int n);
        squash_i   = 1'b0;
        dp_num_i   = '0;
        fu_ready_i = '1;
        for (int c = 0; c < CDB_NUM; c++) begin
            cdb_valid_i[c] = 1'b1;
            cdb_tag_i[c]   = TAG_W'(n * CDB_NUM + c);
        end
    endtask

    // ------------------------------------------------------------------------
    // Compare and advance
    // ------------------------------------------------------------------------
    task automatic check_outputs();
        int exp_avail;
        int e;
        predict_issue();
        exp_avail = predict_avail();
        assert (avail_num_o == CNT_W'(exp_avail)) else
            stop_on_failure($sformatf("Error at %0t ns: avail_num_o is %0d, expected %0d",
                $time, avail_num_o, exp_avail));
        for (int j = 0; j < IS_NUM; j++) begin
            e = pick_idx[j];
            assert (is_valid_o[j] == pick_vld[j]) else
                stop_on_failure($sformatf("Error at %0t ns: is_valid_o[%0d] is %0b, expected %0b",
                    $time, j, is_valid_o[j], pick_vld[j]));
            if (pick_vld[j]) begin
                assert (is_dst_tag_o[j] == m_dst[e] && is_src1_tag_o[j] == m_src1[e]
                        && is_src2_tag_o[j] == m_src2[e] && is_fu_o[j] == m_fu[e]
                        && is_op_o[j] == m_op[e]) else
                    stop_on_failure($sformatf(
                        "Error at %0t ns: channel %0d carries dst %0d op %h, expected dst %0d op %h",
                        $time, j, is_dst_tag_o[j], is_op_o[j], m_dst[e], m_op[e]));
            end
        end
        // Instructions the DUT actually sent out
        issued_cnt += $countones(is_valid_o);
    endtask

    // Sample just before the rising edge, then step the model
    task automatic settle_and_check();
        #4;
        check_outputs();
        apply_edge();
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int rst_cyc;
        int drain_cyc;
        rst_i         = 1'b1;
        squash_i      = 1'b0;
        dp_num_i      = '0;
        dp_dst_tag_i  = '0;
        dp_src1_tag_i = '0;
        dp_src2_tag_i = '0;
        dp_src1_rdy_i = '0;
        dp_src2_rdy_i = '0;
        dp_fu_i       = '0;
        dp_op_i       = '0;
        cdb_valid_i   = '0;
        cdb_tag_i     = '0;
        fu_ready_i    = '0;
        lfsr_q        = 32'hce3280ca;
        next_tag      = '0;
        dispatched_cnt = 0;
        squashed_cnt   = 0;
        issued_cnt     = 0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            m_valid[e] = 1'b0;
        end

        // Hold reset, then wait for an empty station
        rst_cyc = 0;
        while (rst_cyc < RST_CYCLES || is_valid_o != '0
                || avail_num_o != CNT_W'(DP_NUM)) begin
            if (rst_cyc >= 2 * RST_CYCLES) begin
                stop_on_failure("Timeout: the station did not report empty after reset");
            end
            @(negedge clk_i);
            rst_cyc++;
        end
        rst_i = 1'b0;

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            drive_random();
            settle_and_check();
            @(negedge clk_i);
        end

        drain_cyc = 0;
        while (!model_empty() || drain_cyc < BCAST_CYCLES) begin
            if (drain_cyc >= DRAIN_TIMEOUT) begin
                stop_on_failure("Timeout: the station did not drain after all tags were broadcast");
            end
            drive_drain(drain_cyc);
            settle_and_check();
            @(negedge clk_i);
            drain_cyc++;
        end

        // One idle cycle confirms the DUT is empty too
        cdb_valid_i = '0;
        settle_and_check();

        assert (issued_cnt > 0 && issued_cnt == dispatched_cnt - squashed_cnt) else
            stop_on_failure($sformatf("Error at %0t ns: issued %0d, dispatched %0d, squashed %0d",
                $time, issued_cnt, dispatched_cnt, squashed_cnt));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- files.f
+incdir+sim
logic/rs_cfg_pkg.sv
logic/rs_fu_pkg.sv
logic/rs_multi_pick.sv
logic/rs_alloc.sv
logic/rs_entry_array.sv
logic/rs_issue_select.sv
logic/rs_top.sv
sim/tb_rs_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the reservation station testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f files.f \
    --top-module tb_rs_top -Mdir obj_dir -o sim_rs
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_rs)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
